// File: axi_pkg.sv
// ##############################
// AXI-lite bus vector types
// ##############################

package axi_pkg;

  // Byte address on every address channel
  typedef logic [31:0] addr_t;

  // One data beat, read or write
  typedef logic [31:0] data_t;

  typedef logic [3:0] strb_t;  // One strobe bit per data byte

  typedef logic [1:0] resp_t;  // Response code on r and b channels

  // The only response this fabric produces by itself
  localparam resp_t resp_okay = 2'b00;

endpackage

// File: soc_pkg.sv
// ##############################
// CLINT address map and arbiter state
// ##############################

package soc_pkg;

  // Machine timer, read as two 32-bit halves
  typedef logic [63:0] mtime_t;

  localparam axi_pkg::addr_t clint_mtime_lo = 32'ha000_0048;  // Low word of mtime
  localparam axi_pkg::addr_t clint_mtime_hi = 32'ha000_004c;  // High word of mtime

  // A grant is held until the response handshake of its transaction
  typedef enum logic [1:0] {
    arb_idle,
    arb_read,
    arb_write
  } arb_state_t;

endpackage

// File: axi_lite_if.sv
`timescale 1ns/1ps

// Read half of an AXI-lite port, ar and r channels
interface axi_read_if;
  import axi_pkg::*;

  addr_t araddr;
  logic  arvalid;
  logic  arready;

  data_t rdata;
  resp_t rresp;
  logic  rvalid;
  logic  rready;

  modport requester (
    output araddr, arvalid, rready,
    input  arready, rdata, rresp, rvalid
  );

  modport completer (
    input  araddr, arvalid, rready,
    output arready, rdata, rresp, rvalid
  );

endinterface

// Write half of an AXI-lite port, aw, w and b channels
interface axi_write_if;
  import axi_pkg::*;

  addr_t awaddr;
  logic  awvalid;
  logic  awready;

  data_t wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;

  resp_t bresp;
  logic  bvalid;
  logic  bready;

  modport requester (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  awready, wready, bresp, bvalid
  );

  modport completer (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output awready, wready, bresp, bvalid
  );

endinterface

// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic            clock,
  input  logic            reset,
  axi_read_if.completer   fetch,
  axi_read_if.completer   lsu_rd,
  axi_write_if.completer  lsu_wr,
  axi_read_if.requester   clint,
  output axi_pkg::addr_t  ext_araddr,
  output logic            ext_arvalid,
  input  logic            ext_arready,
  input  axi_pkg::data_t  ext_rdata,
  input  axi_pkg::resp_t  ext_rresp,
  input  logic            ext_rvalid,
  output logic            ext_rready,
  output axi_pkg::addr_t  ext_awaddr,
  output logic            ext_awvalid,
  input  logic            ext_awready,
  output axi_pkg::data_t  ext_wdata,
  output axi_pkg::strb_t  ext_wstrb,
  output logic            ext_wvalid,
  input  logic            ext_wready,
  input  axi_pkg::resp_t  ext_bresp,
  input  logic            ext_bvalid,
  output logic            ext_bready
);
  import axi_pkg::*;
  import soc_pkg::*;

  arb_state_t state;
  logic       grant_lsu;     // Low for fetch, high for the load/store unit
  logic       target_clint;  // Low routes the read to the external port

  logic       fetch_sel;
  logic       lsu_sel;
  logic       rd_active;
  logic       wr_active;
  logic       rd_done;
  logic       wr_done;

  // Channels of the granted read requester
  addr_t      rd_araddr;
  logic       rd_arvalid;
  logic       rd_rready;

  // Channels of the selected read target
  logic       rd_arready;
  data_t      rd_rdata;
  resp_t      rd_rresp;
  logic       rd_rvalid;

  function automatic logic is_clint(input addr_t addr);
    return (addr == clint_mtime_lo) || (addr == clint_mtime_hi);
  endfunction

  assign rd_active = (state == arb_read);
  assign wr_active = (state == arb_write);
  assign fetch_sel = rd_active && !grant_lsu;
  assign lsu_sel   = rd_active && grant_lsu;

  // ##############################
  // Read path
  // ##############################

  always_comb begin
    rd_araddr  = '0;
    rd_arvalid = 1'b0;
    rd_rready  = 1'b0;
    if (fetch_sel) begin
      rd_araddr  = fetch.araddr;
      rd_arvalid = fetch.arvalid;
      rd_rready  = fetch.rready;
    end else if (lsu_sel) begin
      rd_araddr  = lsu_rd.araddr;
      rd_arvalid = lsu_rd.arvalid;
      rd_rready  = lsu_rd.rready;
    end
  end

  always_comb begin
    if (target_clint) begin
      rd_arready = clint.arready;
      rd_rdata   = clint.rdata;
      rd_rresp   = clint.rresp;
      rd_rvalid  = clint.rvalid;
    end else begin
      rd_arready = ext_arready;
      rd_rdata   = ext_rdata;
      rd_rresp   = ext_rresp;
      rd_rvalid  = ext_rvalid;
    end
  end

  assign clint.araddr  = target_clint ? rd_araddr : '0;
  assign clint.arvalid = rd_arvalid && target_clint;
  assign clint.rready  = rd_rready && target_clint;

  assign ext_araddr  = target_clint ? '0 : rd_araddr;
  assign ext_arvalid = rd_arvalid && !target_clint;
  assign ext_rready  = rd_rready && !target_clint;

  assign fetch.arready = fetch_sel && rd_arready;
  assign fetch.rdata   = fetch_sel ? rd_rdata : '0;
  assign fetch.rresp   = fetch_sel ? rd_rresp : '0;
  assign fetch.rvalid  = fetch_sel && rd_rvalid;

  assign lsu_rd.arready = lsu_sel && rd_arready;
  assign lsu_rd.rdata   = lsu_sel ? rd_rdata : '0;
  assign lsu_rd.rresp   = lsu_sel ? rd_rresp : '0;
  assign lsu_rd.rvalid  = lsu_sel && rd_rvalid;

  // ##############################
  // Write path, always external
  // ##############################

  assign ext_awaddr  = wr_active ? lsu_wr.awaddr : '0;
  assign ext_awvalid = wr_active && lsu_wr.awvalid;
  assign ext_wdata   = wr_active ? lsu_wr.wdata : '0;
  assign ext_wstrb   = wr_active ? lsu_wr.wstrb : '0;
  assign ext_wvalid  = wr_active && lsu_wr.wvalid;
  assign ext_bready  = wr_active && lsu_wr.bready;

  assign lsu_wr.awready = wr_active && ext_awready;
  assign lsu_wr.wready  = wr_active && ext_wready;
  assign lsu_wr.bresp   = wr_active ? ext_bresp : '0;
  assign lsu_wr.bvalid  = wr_active && ext_bvalid;

  assign rd_done = rd_active && rd_rvalid && rd_rready;
  assign wr_done = ext_bvalid && ext_bready;  // ext_bready is already gated by the grant

  // ##############################
  // Grant FSM
  // ##############################

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= arb_idle;
      grant_lsu    <= 1'b0;
      target_clint <= 1'b0;
    end else begin
      case (state)
        arb_idle: begin
          // Fixed priority, fetch wins over the load/store unit
          if (fetch.arvalid) begin
            state        <= arb_read;
            grant_lsu    <= 1'b0;
            target_clint <= is_clint(fetch.araddr);
          end else if (lsu_rd.arvalid) begin
            state        <= arb_read;
            grant_lsu    <= 1'b1;
            target_clint <= is_clint(lsu_rd.araddr);
          end else if (lsu_wr.awvalid) begin
            state        <= arb_write;
            grant_lsu    <= 1'b1;
            target_clint <= 1'b0;
          end
        end
        arb_read: begin
          if (rd_done) begin
            state        <= arb_idle;
            grant_lsu    <= 1'b0;
            target_clint <= 1'b0;
          end
        end
        arb_write: begin
          if (wr_done) begin
            state     <= arb_idle;
            grant_lsu <= 1'b0;
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

endmodule

// File: clint_timer.sv
`timescale 1ns/1ps

module clint_timer #(
  parameter int unsigned mtime_div = 1
) (
  input  logic          clock,
  input  logic          reset,
  axi_read_if.completer bus
);
  import axi_pkg::*;
  import soc_pkg::*;

  mtime_t      mtime;
  logic [31:0] div_count;
  logic        tick;

  data_t       rdata_q;  // Word captured at the ar handshake
  logic        rvalid_q;
  logic        ar_fire;
  logic        r_fire;

  // ##############################
  // Free-running timer
  // ##############################

  assign tick = (div_count == mtime_div - 1);

  always_ff @(posedge clock) begin
    if (reset) begin
      div_count <= '0;
      mtime     <= '0;
    end else if (tick) begin
      div_count <= '0;
      mtime     <= mtime + 1'b1;
    end else begin
      div_count <= div_count + 1'b1;
    end
  end

  // ##############################
  // Read-only slave port
  // ##############################

  assign ar_fire = bus.arvalid && bus.arready;
  assign r_fire  = bus.rvalid && bus.rready;

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid_q <= 1'b0;
    end else if (ar_fire) begin
      rvalid_q <= 1'b1;
    end else if (r_fire) begin
      rvalid_q <= 1'b0;
    end
  end

  // Address is decoded upstream, bit 2 picks the half
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata_q <= bus.araddr[2] ? mtime[63:32] : mtime[31:0];
    end
  end

  assign bus.arready = !rvalid_q;  // One outstanding read at most
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = resp_okay;

endmodule

// File: bus_top.sv
`timescale 1ns/1ps

module bus_top #(
  parameter int unsigned mtime_div = 1
) (
  input  logic           clock,
  input  logic           reset,

  // Instruction fetch, read only
  input  axi_pkg::addr_t fetch_araddr,
  input  logic           fetch_arvalid,
  output logic           fetch_arready,
  output axi_pkg::data_t fetch_rdata,
  output axi_pkg::resp_t fetch_rresp,
  output logic           fetch_rvalid,
  input  logic           fetch_rready,

  // Load/store unit
  input  axi_pkg::addr_t lsu_araddr,
  input  logic           lsu_arvalid,
  output logic           lsu_arready,
  output axi_pkg::data_t lsu_rdata,
  output axi_pkg::resp_t lsu_rresp,
  output logic           lsu_rvalid,
  input  logic           lsu_rready,
  input  axi_pkg::addr_t lsu_awaddr,
  input  logic           lsu_awvalid,
  output logic           lsu_awready,
  input  axi_pkg::data_t lsu_wdata,
  input  axi_pkg::strb_t lsu_wstrb,
  input  logic           lsu_wvalid,
  output logic           lsu_wready,
  output axi_pkg::resp_t lsu_bresp,
  output logic           lsu_bvalid,
  input  logic           lsu_bready,

  // External AXI-lite master port
  output axi_pkg::addr_t ext_araddr,
  output logic           ext_arvalid,
  input  logic           ext_arready,
  input  axi_pkg::data_t ext_rdata,
  input  axi_pkg::resp_t ext_rresp,
  input  logic           ext_rvalid,
  output logic           ext_rready,
  output axi_pkg::addr_t ext_awaddr,
  output logic           ext_awvalid,
  input  logic           ext_awready,
  output axi_pkg::data_t ext_wdata,
  output axi_pkg::strb_t ext_wstrb,
  output logic           ext_wvalid,
  input  logic           ext_wready,
  input  axi_pkg::resp_t ext_bresp,
  input  logic           ext_bvalid,
  output logic           ext_bready
);

  axi_read_if  fetch_rd ();
  axi_read_if  lsu_rd ();
  axi_write_if lsu_wr ();
  axi_read_if  clint_rd ();  // Arbiter to CLINT

  // ##############################
  // Requester ports to interfaces
  // ##############################

  assign fetch_rd.araddr  = fetch_araddr;
  assign fetch_rd.arvalid = fetch_arvalid;
  assign fetch_rd.rready  = fetch_rready;
  assign fetch_arready    = fetch_rd.arready;
  assign fetch_rdata      = fetch_rd.rdata;
  assign fetch_rresp      = fetch_rd.rresp;
  assign fetch_rvalid     = fetch_rd.rvalid;

  assign lsu_rd.araddr  = lsu_araddr;
  assign lsu_rd.arvalid = lsu_arvalid;
  assign lsu_rd.rready  = lsu_rready;
  assign lsu_arready    = lsu_rd.arready;
  assign lsu_rdata      = lsu_rd.rdata;
  assign lsu_rresp      = lsu_rd.rresp;
  assign lsu_rvalid     = lsu_rd.rvalid;

  assign lsu_wr.awaddr  = lsu_awaddr;
  assign lsu_wr.awvalid = lsu_awvalid;
  assign lsu_wr.wdata   = lsu_wdata;
  assign lsu_wr.wstrb   = lsu_wstrb;
  assign lsu_wr.wvalid  = lsu_wvalid;
  assign lsu_wr.bready  = lsu_bready;
  assign lsu_awready    = lsu_wr.awready;
  assign lsu_wready     = lsu_wr.wready;
  assign lsu_bresp      = lsu_wr.bresp;
  assign lsu_bvalid     = lsu_wr.bvalid;

  bus_arbiter i_bus_arbiter (
    .clock       (clock),
    .reset       (reset),
    .fetch       (fetch_rd.completer),
    .lsu_rd      (lsu_rd.completer),
    .lsu_wr      (lsu_wr.completer),
    .clint       (clint_rd.requester),
    .ext_araddr  (ext_araddr),
    .ext_arvalid (ext_arvalid),
    .ext_arready (ext_arready),
    .ext_rdata   (ext_rdata),
    .ext_rresp   (ext_rresp),
    .ext_rvalid  (ext_rvalid),
    .ext_rready  (ext_rready),
    .ext_awaddr  (ext_awaddr),
    .ext_awvalid (ext_awvalid),
    .ext_awready (ext_awready),
    .ext_wdata   (ext_wdata),
    .ext_wstrb   (ext_wstrb),
    .ext_wvalid  (ext_wvalid),
    .ext_wready  (ext_wready),
    .ext_bresp   (ext_bresp),
    .ext_bvalid  (ext_bvalid),
    .ext_bready  (ext_bready)
  );

  clint_timer #(
    .mtime_div (mtime_div)
  ) i_clint_timer (
    .clock (clock),
    .reset (reset),
    .bus   (clint_rd.completer)
  );

endmodule

// File: bus_checker.sv
`timescale 1ns/1ps

module bus_checker (
  input logic           clock,
  input logic           reset,
  input logic           fetch_arready,
  input logic           fetch_rvalid,
  input logic           lsu_arready,
  input logic           lsu_rvalid,
  input logic           lsu_awready,
  input logic           lsu_wready,
  input logic           lsu_bvalid,
  input axi_pkg::addr_t ext_araddr,
  input logic           ext_arvalid,
  input logic           ext_arready,
  input axi_pkg::addr_t ext_awaddr,
  input logic           ext_awvalid,
  input logic           ext_awready,
  input axi_pkg::data_t ext_wdata,
  input axi_pkg::strb_t ext_wstrb,
  input logic           ext_wvalid,
  input logic           ext_wready
);
  import soc_pkg::*;

  int unsigned fail_count = 0;

  logic fetch_seen;
  logic lsu_seen;
  logic wr_seen;

  assign fetch_seen = fetch_arready || fetch_rvalid;
  assign lsu_seen   = lsu_arready || lsu_rvalid;
  assign wr_seen    = lsu_awready || lsu_wready || lsu_bvalid;

  // ##############################
  // Grant and protocol properties
  // ##############################

  one_requester: assert property (@(posedge clock) disable iff (reset)
    $onehot0({fetch_seen, lsu_seen, wr_seen}))
    else begin
      fail_count++;
      $error("more than one requester sees a ready or valid");
    end

  // Reads of the timer words belong to the CLINT alone
  clint_hides_ext: assert property (@(posedge clock) disable iff (reset)
    ext_arvalid |-> ext_araddr != clint_mtime_lo && ext_araddr != clint_mtime_hi)
    else begin
      fail_count++;
      $error("a CLINT read reached the external ar channel");
    end

  ar_stable: assert property (@(posedge clock) disable iff (reset)
    ext_arvalid && !ext_arready |=> ext_arvalid && $stable(ext_araddr))
    else begin
      fail_count++;
      $error("ext ar channel changed before its handshake");
    end

  aw_stable: assert property (@(posedge clock) disable iff (reset)
    ext_awvalid && !ext_awready |=> ext_awvalid && $stable(ext_awaddr))
    else begin
      fail_count++;
      $error("ext aw channel changed before its handshake");
    end

  w_stable: assert property (@(posedge clock) disable iff (reset)
    ext_wvalid && !ext_wready |=> ext_wvalid && $stable(ext_wdata) && $stable(ext_wstrb))
    else begin
      fail_count++;
      $error("ext w channel changed before its handshake");
    end

  // Nothing may be valid in the first cycle out of reset
  quiet_after_reset: assert property (@(posedge clock)
    reset |=> !ext_arvalid && !ext_awvalid && !ext_wvalid && !fetch_rvalid && !lsu_rvalid
              && !lsu_bvalid)
    else begin
      fail_count++;
      $error("a valid is high in the cycle after reset");
    end

endmodule

bind bus_arbiter bus_checker i_bus_checker (
  .clock         (clock),
  .reset         (reset),
  .fetch_arready (fetch.arready),
  .fetch_rvalid  (fetch.rvalid),
  .lsu_arready   (lsu_rd.arready),
  .lsu_rvalid    (lsu_rd.rvalid),
  .lsu_awready   (lsu_wr.awready),
  .lsu_wready    (lsu_wr.wready),
  .lsu_bvalid    (lsu_wr.bvalid),
  .ext_araddr    (ext_araddr),
  .ext_arvalid   (ext_arvalid),
  .ext_arready   (ext_arready),
  .ext_awaddr    (ext_awaddr),
  .ext_awvalid   (ext_awvalid),
  .ext_awready   (ext_awready),
  .ext_wdata     (ext_wdata),
  .ext_wstrb     (ext_wstrb),
  .ext_wvalid    (ext_wvalid),
  .ext_wready    (ext_wready)
);

// File: tb_bus_top.sv
`timescale 1ns/1ps

module tb_bus_top;
  import axi_pkg::*;
  import soc_pkg::*;

  localparam int unsigned mtime_div = 2;
  localparam int          num_tests = 6;
  localparam addr_t       ext_base  = 32'h8000_0000;  // Slave memory sits at the bottom of this

  logic  clock;
  logic  reset;
  addr_t fetch_araddr;
  logic  fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready;
  data_t fetch_rdata;
  resp_t fetch_rresp;
  addr_t lsu_araddr, lsu_awaddr;
  logic  lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
  logic  lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
  data_t lsu_rdata, lsu_wdata;
  strb_t lsu_wstrb;
  resp_t lsu_rresp, lsu_bresp;
  addr_t ext_araddr, ext_awaddr;
  logic  ext_arvalid, ext_arready, ext_rvalid, ext_rready;
  logic  ext_awvalid, ext_awready, ext_wvalid, ext_wready, ext_bvalid, ext_bready;
  data_t ext_rdata, ext_wdata;
  strb_t ext_wstrb;
  resp_t ext_rresp, ext_bresp;

  data_t mem [64];
  addr_t ext_ar_log [$];  // Every address accepted on the external ar channel
  addr_t last_awaddr;
  data_t last_wdata;
  strb_t last_wstrb;
  int    cycle;
  int    test_num, test_errors, pass_count, fail_count, chk_seen;

  bus_top #(.mtime_div(mtime_div)) i_bus_top (.*);

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;
    if (ext_arvalid && ext_arready) begin
      ext_ar_log.push_back(ext_araddr);
    end
  end

  function automatic data_t fill_word(input addr_t addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
  endfunction

  // ##############################
  // External slave model
  // ##############################

  initial begin
    addr_t addr;
    ext_arready = 1'b0;
    ext_rvalid  = 1'b0;
    ext_rdata   = '0;
    ext_rresp   = resp_okay;
    for (int i = 0; i < 64; i++) begin
      mem[i] = fill_word(ext_base + 4 * i);
    end
    forever begin
      @(posedge clock);
      if (ext_arvalid) begin
        addr = ext_araddr;
        repeat ($urandom_range(3)) @(posedge clock);
        @(negedge clock);
        ext_arready = 1'b1;
        @(negedge clock);
        ext_arready = 1'b0;
        repeat ($urandom_range(3)) @(negedge clock);
        ext_rdata  = mem[addr[7:2]];
        ext_rvalid = 1'b1;
        do @(posedge clock); while (!ext_rready);
        @(negedge clock);
        ext_rvalid = 1'b0;
      end
    end
  end

  initial begin
    addr_t addr;
    ext_awready = 1'b0;
    ext_wready  = 1'b0;
    ext_bvalid  = 1'b0;
    ext_bresp   = resp_okay;
    forever begin
      @(posedge clock);
      if (ext_awvalid) begin
        addr        = ext_awaddr;
        last_awaddr = ext_awaddr;
        repeat ($urandom_range(3)) @(posedge clock);
        @(negedge clock);
        ext_awready = 1'b1;
        @(negedge clock);
        ext_awready = 1'b0;
        repeat ($urandom_range(3)) @(posedge clock);
        @(negedge clock);
        ext_wready = 1'b1;
        do @(posedge clock); while (!ext_wvalid);
        last_wdata = ext_wdata;
        last_wstrb = ext_wstrb;
        for (int b = 0; b < 4; b++) begin
          if (ext_wstrb[b]) begin
            mem[addr[7:2]][8*b +: 8] = ext_wdata[8*b +: 8];  // Only strobed bytes change
          end
        end
        @(negedge clock);
        ext_wready = 1'b0;
        repeat ($urandom_range(3)) @(negedge clock);
        ext_bvalid = 1'b1;
        do @(posedge clock); while (!ext_bready);
        @(negedge clock);
        ext_bvalid = 1'b0;
      end
    end
  end

  // ##############################
  // Requester tasks and checks
  // ##############################

  task automatic fetch_read(input addr_t addr, input int stall, output data_t data,
                            output resp_t resp, output int ar_cyc, output int r_cyc);
    @(negedge clock);
    fetch_araddr  = addr;
    fetch_arvalid = 1'b1;
    do @(posedge clock); while (!fetch_arready);
    ar_cyc = cycle;
    @(negedge clock);
    fetch_arvalid = 1'b0;
    repeat (stall) @(negedge clock);  // Hold off the response
    fetch_rready = 1'b1;
    do @(posedge clock); while (!fetch_rvalid);
    r_cyc = cycle;
    data  = fetch_rdata;
    resp  = fetch_rresp;
    @(negedge clock);
    fetch_rready = 1'b0;
  endtask

  task automatic lsu_read(input addr_t addr, input int stall, output data_t data,
                          output resp_t resp, output int ar_cyc, output int r_cyc);
    @(negedge clock);
    lsu_araddr  = addr;
    lsu_arvalid = 1'b1;
    do @(posedge clock); while (!lsu_arready);
    ar_cyc = cycle;
    @(negedge clock);
    lsu_arvalid = 1'b0;
    repeat (stall) @(negedge clock);
    lsu_rready = 1'b1;
    do @(posedge clock); while (!lsu_rvalid);
    r_cyc = cycle;
    data  = lsu_rdata;
    resp  = lsu_rresp;
    @(negedge clock);
    lsu_rready = 1'b0;
  endtask

  task automatic lsu_write(input addr_t addr, input data_t data, input strb_t strb,
                           output resp_t resp);
    logic aw_fire;
    logic w_fire;
    @(negedge clock);
    lsu_awaddr  = addr;
    lsu_awvalid = 1'b1;
    lsu_wdata   = data;
    lsu_wstrb   = strb;
    lsu_wvalid  = 1'b1;
    lsu_bready  = 1'b1;
    while (lsu_awvalid || lsu_wvalid) begin
      @(posedge clock);
      aw_fire = lsu_awvalid && lsu_awready;
      w_fire  = lsu_wvalid && lsu_wready;
      @(negedge clock);
      if (aw_fire) begin
        lsu_awvalid = 1'b0;
      end
      if (w_fire) begin
        lsu_wvalid = 1'b0;
      end
    end
    do @(posedge clock); while (!lsu_bvalid);
    resp = lsu_bresp;
    @(negedge clock);
    lsu_bready = 1'b0;
  endtask

  task automatic expect_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
    assert (actual === expected) else begin
      test_errors++;
      $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      test_errors++;
      $display("at %0t ns: %s", $time, what);
    end
  endtask

  task automatic end_test(input string name);
    int chk;
    chk = i_bus_top.i_bus_arbiter.i_bus_checker.fail_count;
    test_num++;
    if (test_errors == 0 && chk == chk_seen) begin
      pass_count++;
      $display("test %0d, %s: ok", test_num, name);
    end else begin
      fail_count++;
      $display("test %0d, %s: failed", test_num, name);
    end
    test_errors = 0;
    chk_seen    = chk;
  endtask

  // ##############################
  // Test sequence
  // ##############################

  initial begin
    data_t  d0, d1, hi, lo;
    resp_t  r0, r1;
    int     c0, c1, a0, a1, n_ext;
    addr_t  a;
    mtime_t t0, t1;
    void'($urandom(31));
    clock         = 1'b0;
    reset         = 1'b1;
    cycle         = 0;
    fetch_araddr  = '0;
    fetch_arvalid = 1'b0;
    fetch_rready  = 1'b0;
    lsu_araddr    = '0;
    lsu_arvalid   = 1'b0;
    lsu_rready    = 1'b0;
    lsu_awaddr    = '0;
    lsu_awvalid   = 1'b0;
    lsu_wdata     = '0;
    lsu_wstrb     = '0;
    lsu_wvalid    = 1'b0;
    lsu_bready    = 1'b0;
    test_num      = 0;
    test_errors   = 0;
    pass_count    = 0;
    fail_count    = 0;
    chk_seen      = 0;
    repeat (3) @(negedge clock);
    reset = 1'b0;

    repeat (2) @(negedge clock);
    expect_value("{fetch_arready, fetch_rvalid}", {fetch_arready, fetch_rvalid}, 0);
    expect_value("{lsu_arready, lsu_rvalid, lsu_awready, lsu_wready, lsu_bvalid}",
                 {lsu_arready, lsu_rvalid, lsu_awready, lsu_wready, lsu_bvalid}, 0);
    expect_value("{ext_arvalid, ext_awvalid, ext_wvalid}",
                 {ext_arvalid, ext_awvalid, ext_wvalid}, 0);
    end_test("idle after reset");

    a = ext_base + 32'h24;
    fetch_read(a, 0, d0, r0, c0, c1);
    expect_value("ext_araddr", ext_ar_log[$], a);
    expect_value("fetch_rdata", d0, fill_word(a));
    expect_value("fetch_rresp", r0, resp_okay);
    end_test("fetch read from external port");

    n_ext = ext_ar_log.size();
    fork
      fetch_read(ext_base + 32'h40, 0, d0, r0, c0, c1);
      lsu_read(ext_base + 32'h84, 0, d1, r1, a0, a1);
    join
    expect_value("ext_araddr", ext_ar_log[n_ext], ext_base + 32'h40);
    expect_value("ext_araddr", ext_ar_log[n_ext + 1], ext_base + 32'h84);
    expect_value("fetch_rdata", d0, fill_word(ext_base + 32'h40));
    expect_value("lsu_rdata", d1, fill_word(ext_base + 32'h84));
    expect_true(a0 > c1, "lsu read was accepted before the fetch read completed");
    end_test("fetch wins over lsu");

    a = ext_base + 32'hc8;
    lsu_write(a, 32'hdead_beef, 4'b0101, r0);
    expect_value("ext_awaddr", last_awaddr, a);
    expect_value("ext_wdata", last_wdata, 32'hdead_beef);
    expect_value("ext_wstrb", last_wstrb, 4'b0101);
    expect_value("lsu_bresp", r0, resp_okay);
    lsu_read(a, 0, d1, r1, c0, c1);
    d0 = fill_word(a);
    expect_value("lsu_rdata", d1, {d0[31:24], 8'had, d0[15:8], 8'hef});
    end_test("lsu write then read back");

    n_ext = ext_ar_log.size();
    fetch_read(clint_mtime_hi, 0, hi, r0, c0, c1);
    fetch_read(clint_mtime_lo, 0, lo, r1, a0, c1);
    expect_value("fetch_rresp", {r0, r1}, {resp_okay, resp_okay});
    t0 = {hi, lo};
    repeat (9) @(negedge clock);
    lsu_read(clint_mtime_hi, 0, hi, r0, c0, c1);
    lsu_read(clint_mtime_lo, 0, lo, r1, a1, c1);
    expect_value("lsu_rresp", {r0, r1}, {resp_okay, resp_okay});
    t1 = {hi, lo};
    expect_true(t1 >= t0, "mtime went backwards between two reads");
    expect_true(t1 - t0 <= (a1 - a0) / mtime_div + 1, "mtime advanced faster than its divider");
    expect_true(t1 - t0 + 1 >= (a1 - a0) / mtime_div, "mtime advanced slower than its divider");
    expect_true(ext_ar_log.size() == n_ext, "a CLINT read reached the external port");
    end_test("CLINT mtime reads");

    fork
      fetch_read(ext_base + 32'h58, 3, d0, r0, c0, c1);
      lsu_read(ext_base + 32'h9c, 2, d1, r1, a0, a1);
    join
    expect_value("fetch_rdata", d0, fill_word(ext_base + 32'h58));
    expect_value("lsu_rdata", d1, fill_word(ext_base + 32'h9c));
    expect_true(a0 > c1, "lsu read was accepted during a stalled fetch read");
    repeat (4) begin
      a = ext_base + ($urandom_range(63) << 2);
      fork
        fetch_read(a, $urandom_range(3), d0, r0, c0, c1);
        lsu_read(a ^ 32'h80, $urandom_range(3), d1, r1, a0, a1);
      join
      expect_value("fetch_rdata", d0, mem[a[7:2]]);
      expect_value("lsu_rdata", d1, mem[a[7:2] ^ 6'h20]);
    end
    end_test("random delays and stalled rready");

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (num_tests * 200) @(posedge clock);
    $display("watchdog expired after %0d cycles, a handshake never completed", num_tests * 200);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: flist.f
axi_pkg.sv
soc_pkg.sv
axi_lite_if.sv
bus_arbiter.sv
clint_timer.sv
bus_top.sv
bus_checker.sv
tb_bus_top.sv

// File: Makefile
TOP = tb_bus_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -o sim_bus
	./obj_dir/sim_bus | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
